// File: ofdm_pkg.sv
package ofdm_pkg;

    // one complex sample has the imaginary part in the upper half and the real part in the lower
    parameter int SAMPLE_W = 32;
    parameter int COMP_W   = SAMPLE_W / 2;

    // the accumulator holds FFT_LEN products of 16x16 bits with room to spare
    parameter int ACC_W = 40;

    // cyclic-prefix length as it arrives with the first sample of a symbol
    parameter int CP_LEN_W = 6;

    // running symbol index, wraps at 2**SYM_IDX_W
    parameter int SYM_IDX_W = 8;

    // twiddles are rounded to this scale, which is close enough to 2**15
    // that a shift by 15 undoes it
    parameter int TWID_SCALE = 32767;

    typedef logic [SAMPLE_W-1:0]         sample_t;
    typedef logic signed [COMP_W-1:0]    comp_t;
    typedef logic signed [ACC_W-1:0]     acc_t;
    typedef logic [CP_LEN_W-1:0]         cp_len_t;
    typedef logic [SYM_IDX_W-1:0]        sym_idx_t;

endpackage

// File: cp_remover.sv
`timescale 1ns/10ps

module cp_remover #(
    parameter int FFT_LOG2 = 4
) (
    input  logic                  clk_i,
    input  logic                  reset_ni,
    input  logic                  in_valid_i,
    input  ofdm_pkg::sample_t     in_data_i,
    input  ofdm_pkg::cp_len_t     in_cp_len_i,
    input  logic                  in_last_i,
    input  logic                  wr_bank_free_i,
    output logic                  wr_en_o,
    output logic [FFT_LOG2-1:0]   wr_addr_o,
    output ofdm_pkg::sample_t     wr_data_o,
    output logic                  wr_done_o,
    output ofdm_pkg::sym_idx_t    wr_sym_o,
    output logic                  overflow_o
);
    import ofdm_pkg::*;

    localparam int FFT_LEN = 1 << FFT_LOG2;
    localparam logic [FFT_LOG2-1:0] LAST_ADDR = FFT_LOG2'(FFT_LEN - 1);

    typedef enum logic [1:0] {
        S_SKIP_CP,
        S_KEEP,
        S_SKIP_TAIL,
        S_DROP
    } state_t;

    state_t              state;
    logic                sym_start;     // next valid sample opens a new symbol
    cp_len_t             cp_len;
    cp_len_t             cp_cnt;
    logic [FFT_LOG2-1:0] cnt;
    sym_idx_t            sym_idx;

    cp_len_t             cur_len;
    cp_len_t             cur_cnt;
    logic                drop_now;
    logic                in_prefix;
    logic                keep;
    logic [FFT_LOG2-1:0] keep_addr;

    // the prefix length and counter come straight from the input on the first sample
    assign cur_len   = sym_start ? in_cp_len_i : cp_len;
    assign cur_cnt   = sym_start ? '0 : cp_cnt;
    assign drop_now  = in_valid_i && state == S_SKIP_CP && sym_start && !wr_bank_free_i;
    assign in_prefix = state == S_SKIP_CP && cur_cnt < cur_len;
    assign keep      = in_valid_i && !drop_now &&
                       (state == S_KEEP || (state == S_SKIP_CP && !in_prefix));
    assign keep_addr = (state == S_KEEP) ? cnt : '0;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state      <= S_SKIP_CP;
            sym_start  <= 1'b1;
            sym_idx    <= '0;
            wr_en_o    <= 1'b0;
            wr_done_o  <= 1'b0;
            overflow_o <= 1'b0;
        end else begin
            wr_en_o    <= keep;
            wr_done_o  <= keep && keep_addr == LAST_ADDR;
            overflow_o <= drop_now;                     // one pulse per dropped symbol
            if (in_valid_i) begin
                sym_start <= in_last_i;
                if (in_last_i) sym_idx <= sym_idx + 1'b1; // dropped symbols count too
                if (sym_start) cp_len <= in_cp_len_i;
                if (drop_now) begin
                    if (!in_last_i) state <= S_DROP;
                end else if (in_prefix) begin
                    cp_cnt <= cur_cnt + 1'b1;
                end else if (keep) begin
                    cnt <= keep_addr + 1'b1;
                    if (keep_addr == LAST_ADDR) begin
                        state <= in_last_i ? S_SKIP_CP : S_SKIP_TAIL;
                    end else if (in_last_i) begin
                        state <= S_SKIP_CP;             // short symbol, the bank gets rewritten
                    end else begin
                        state <= S_KEEP;
                    end
                end else if (in_last_i) begin
                    state <= S_SKIP_CP;                 // end of tail or of a dropped symbol
                end
            end
        end
    end

    // write payload, registered together with wr_en_o
    always_ff @(posedge clk_i) begin
        if (keep) begin
            wr_addr_o <= keep_addr;
            wr_data_o <= in_data_i;
            wr_sym_o  <= sym_idx;
        end
    end

    a_addr_no_wrap: assert property (@(posedge clk_i) disable iff (!reset_ni)
        wr_en_o && wr_addr_o == LAST_ADDR |=> !wr_en_o || wr_addr_o == '0)
        else $error("cp_remover: write address ran past the end of the symbol");

    a_last_after_cp: assert property (@(posedge clk_i) disable iff (!reset_ni)
        in_valid_i && in_last_i |-> !in_prefix)
        else $error("cp_remover: symbol ended inside its cyclic prefix");

endmodule

// File: symbol_buffer.sv
`timescale 1ns/10ps

module symbol_buffer #(
    parameter int FFT_LOG2 = 4
) (
    input  logic                  clk_i,
    input  logic                  reset_ni,
    input  logic                  wr_en_i,
    input  logic [FFT_LOG2-1:0]   wr_addr_i,
    input  ofdm_pkg::sample_t     wr_data_i,
    input  logic                  wr_done_i,
    input  ofdm_pkg::sym_idx_t    wr_sym_i,
    output logic                  wr_bank_free_o,
    output logic                  rd_ready_o,
    output ofdm_pkg::sym_idx_t    rd_sym_o,
    input  logic                  rd_release_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic [FFT_LOG2-1:0]   wb_adr_i,
    output ofdm_pkg::sample_t     wb_dat_o,
    output logic                  wb_ack_o
);
    import ofdm_pkg::*;

    localparam int FFT_LEN = 1 << FFT_LOG2;

    sample_t    mem [2*FFT_LEN];    // bank 0 in the lower half, bank 1 in the upper
    sym_idx_t   bank_sym [2];
    logic [1:0] full;
    logic       wr_ptr;
    logic       rd_ptr;

    // a symbol that completes in this cycle already hands the write side to the other bank
    assign wr_bank_free_o = wr_done_i ? !full[~wr_ptr] : !full[wr_ptr];
    assign rd_ready_o     = full[rd_ptr];
    assign rd_sym_o       = bank_sym[rd_ptr];

    // bank status, the write and read pointers each flip when their bank changes hands
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            full   <= 2'b00;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
        end else begin
            if (wr_done_i) begin
                full[wr_ptr] <= 1'b1;
                wr_ptr       <= ~wr_ptr;
            end
            if (rd_release_i) begin
                full[rd_ptr] <= 1'b0;
                rd_ptr       <= ~rd_ptr;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en_i) mem[{wr_ptr, wr_addr_i}] <= wr_data_i;
        if (wr_done_i) bank_sym[wr_ptr] <= wr_sym_i;
    end

    // classic single read, ack one cycle after the strobe
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= wb_cyc_i && wb_stb_i && !wb_ack_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wb_cyc_i && wb_stb_i) wb_dat_o <= mem[{rd_ptr, wb_adr_i}];
    end

    a_no_write_full: assert property (@(posedge clk_i) disable iff (!reset_ni)
        wr_en_i |-> !full[wr_ptr])
        else $error("symbol_buffer: write into a full bank");

    a_no_release_empty: assert property (@(posedge clk_i) disable iff (!reset_ni)
        rd_release_i |-> full[rd_ptr])
        else $error("symbol_buffer: release of an empty bank");

    a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (!reset_ni)
        wb_ack_o |-> wb_cyc_i)
        else $error("symbol_buffer: ack outside a bus cycle");

endmodule

// File: dft_engine.sv
`timescale 1ns/10ps

module dft_engine #(
    parameter int FFT_LOG2      = 4,
    parameter int BAND_START    = 2,
    parameter int BAND_LEN      = 12,
    parameter int SYMS_PER_SYNC = 14
) (
    input  logic                  clk_i,
    input  logic                  reset_ni,
    input  logic                  rd_ready_i,
    input  ofdm_pkg::sym_idx_t    rd_sym_i,
    output logic                  rd_release_o,
    output logic                  wb_cyc_o,
    output logic                  wb_stb_o,
    output logic [FFT_LOG2-1:0]   wb_adr_o,
    input  ofdm_pkg::sample_t     wb_dat_i,
    input  logic                  wb_ack_i,
    output logic                  out_valid_o,
    output ofdm_pkg::sample_t     out_data_o,
    output logic                  out_last_o,
    output ofdm_pkg::sym_idx_t    out_sym_o,
    output logic                  out_sync_o
);
    import ofdm_pkg::*;

    localparam int  FFT_LEN = 1 << FFT_LOG2;
    localparam int  SHIFT   = 15 + FFT_LOG2;   // undoes the twiddle scale and the 1/N growth
    localparam int  BIN_W   = $clog2(BAND_LEN + 1);
    localparam real PI      = 3.14159265358979;

    localparam logic [FFT_LOG2-1:0] LAST_N  = FFT_LOG2'(FFT_LEN - 1);
    localparam logic [FFT_LOG2-1:0] FIRST_K = FFT_LOG2'(BAND_START + FFT_LEN / 2);
    localparam logic [BIN_W-1:0]    LAST_BIN = BIN_W'(BAND_LEN - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ,
        S_ACC,
        S_SCALE,
        S_EMIT,
        S_RELEASE
    } state_t;

    state_t                   state;
    logic [FFT_LOG2-1:0]      n;        // sample index, also the bus address
    logic [FFT_LOG2-1:0]      k;        // natural bin of the current output
    logic [FFT_LOG2-1:0]      tw_idx;   // (k*n) mod FFT_LEN, stepped by k
    logic [BIN_W-1:0]         bin;
    sym_idx_t                 sym;
    acc_t                     acc_re;
    acc_t                     acc_im;
    comp_t                    sc_re;
    comp_t                    sc_im;

    comp_t                    tw_re [FFT_LEN];
    comp_t                    tw_im [FFT_LEN];
    comp_t                    x_re;
    comp_t                    x_im;
    logic signed [2*COMP_W-1:0] p_rr;
    logic signed [2*COMP_W-1:0] p_ii;
    logic signed [2*COMP_W-1:0] p_ri;
    logic signed [2*COMP_W-1:0] p_ir;
    logic                     last_bin;

    // twiddle table w[i] = exp(-j*2*pi*i/N), fixed at elaboration
    for (genvar i = 0; i < FFT_LEN; i++) begin : g_twid
        localparam real ANG  = 2.0 * PI * i / FFT_LEN;
        localparam int  TW_C = int'(TWID_SCALE * $cos(ANG));
        localparam int  TW_S = int'(-TWID_SCALE * $sin(ANG));
        assign tw_re[i] = comp_t'(TW_C);
        assign tw_im[i] = comp_t'(TW_S);
    end

    assign x_re = comp_t'(wb_dat_i[COMP_W-1:0]);
    assign x_im = comp_t'(wb_dat_i[SAMPLE_W-1:COMP_W]);

    assign p_rr = x_re * tw_re[tw_idx];
    assign p_ii = x_im * tw_im[tw_idx];
    assign p_ri = x_re * tw_im[tw_idx];
    assign p_ir = x_im * tw_re[tw_idx];

    assign last_bin     = bin == LAST_BIN;
    assign wb_adr_o     = n;
    assign rd_release_o = state == S_RELEASE;  // the bank is no longer read after the last bin

    // control: two cycles per read, then one to scale and one to emit
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state       <= S_IDLE;
            wb_cyc_o    <= 1'b0;
            wb_stb_o    <= 1'b0;
            out_valid_o <= 1'b0;
            out_last_o  <= 1'b0;
        end else begin
            out_valid_o <= 1'b0;
            out_last_o  <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (rd_ready_i) begin
                        wb_cyc_o <= 1'b1;
                        wb_stb_o <= 1'b1;
                        state    <= S_READ;
                    end
                end
                S_READ: begin
                    wb_stb_o <= 1'b0;                   // low again in the ack cycle
                    state    <= S_ACC;
                end
                S_ACC: begin
                    if (wb_ack_i) begin
                        if (n == LAST_N) begin
                            wb_cyc_o <= 1'b0;
                            state    <= S_SCALE;
                        end else begin
                            wb_stb_o <= 1'b1;
                            state    <= S_READ;
                        end
                    end
                end
                S_SCALE: state <= S_EMIT;
                S_EMIT: begin
                    out_valid_o <= 1'b1;
                    out_last_o  <= last_bin;
                    if (last_bin) begin
                        state <= S_RELEASE;
                    end else begin
                        wb_cyc_o <= 1'b1;
                        wb_stb_o <= 1'b1;
                        state    <= S_READ;
                    end
                end
                S_RELEASE: state <= S_IDLE;
                default:   state <= S_IDLE;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk_i) begin
        case (state)
            S_IDLE: begin
                if (rd_ready_i) begin
                    sym    <= rd_sym_i;
                    bin    <= '0;
                    k      <= FIRST_K;              // DC-centred order starts below DC
                    n      <= '0;
                    tw_idx <= '0;
                    acc_re <= '0;
                    acc_im <= '0;
                end
            end
            S_ACC: begin
                if (wb_ack_i) begin
                    acc_re <= acc_re + acc_t'(p_rr) - acc_t'(p_ii);
                    acc_im <= acc_im + acc_t'(p_ri) + acc_t'(p_ir);
                    n      <= n + 1'b1;
                    tw_idx <= tw_idx + k;
                end
            end
            S_SCALE: begin
                sc_re <= comp_t'(acc_re >>> SHIFT);
                sc_im <= comp_t'(acc_im >>> SHIFT);
            end
            S_EMIT: begin
                out_data_o <= {sc_im, sc_re};
                out_sym_o  <= sym;
                out_sync_o <= (int'(sym) % SYMS_PER_SYNC) == 0;
                bin        <= bin + 1'b1;
                k          <= k + 1'b1;
                n          <= '0;
                tw_idx     <= '0;
                acc_re     <= '0;
                acc_im     <= '0;
            end
            default: ;
        endcase
    end

    a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!reset_ni)
        wb_stb_o |-> wb_cyc_o)
        else $error("dft_engine: strobe without bus cycle");

    a_stb_drop_on_ack: assert property (@(posedge clk_i) disable iff (!reset_ni)
        wb_ack_i |-> !wb_stb_o)
        else $error("dft_engine: strobe still high in the ack cycle");

endmodule

// File: ofdm_demod_top.sv
`timescale 1ns/10ps

module ofdm_demod_top #(
    parameter int FFT_LOG2      = 4,
    parameter int BAND_START    = 2,
    parameter int BAND_LEN      = 12,
    parameter int SYMS_PER_SYNC = 14
) (
    input  logic                  clk_i,
    input  logic                  reset_ni,
    input  logic                  in_valid_i,
    input  ofdm_pkg::sample_t     in_data_i,
    input  ofdm_pkg::cp_len_t     in_cp_len_i,
    input  logic                  in_last_i,
    output logic                  out_valid_o,
    output ofdm_pkg::sample_t     out_data_o,
    output logic                  out_last_o,
    output ofdm_pkg::sym_idx_t    out_sym_o,
    output logic                  out_sync_o,
    output logic                  overflow_o
);
    import ofdm_pkg::*;

    // write side, cp_remover into the ping-pong banks
    logic                wr_en;
    logic [FFT_LOG2-1:0] wr_addr;
    sample_t             wr_data;
    logic                wr_done;
    sym_idx_t            wr_sym;
    logic                wr_bank_free;

    // read side, Wishbone classic between the engine and the banks
    logic                rd_ready;
    sym_idx_t            rd_sym;
    logic                rd_release;
    logic                wb_cyc;
    logic                wb_stb;
    logic [FFT_LOG2-1:0] wb_adr;
    sample_t             wb_dat;
    logic                wb_ack;

    cp_remover #(
        .FFT_LOG2(FFT_LOG2)
    ) cp_remover_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .in_valid_i     (in_valid_i),
        .in_data_i      (in_data_i),
        .in_cp_len_i    (in_cp_len_i),
        .in_last_i      (in_last_i),
        .wr_bank_free_i (wr_bank_free),
        .wr_en_o        (wr_en),
        .wr_addr_o      (wr_addr),
        .wr_data_o      (wr_data),
        .wr_done_o      (wr_done),
        .wr_sym_o       (wr_sym),
        .overflow_o     (overflow_o)
    );

    symbol_buffer #(
        .FFT_LOG2(FFT_LOG2)
    ) symbol_buffer_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .wr_en_i        (wr_en),
        .wr_addr_i      (wr_addr),
        .wr_data_i      (wr_data),
        .wr_done_i      (wr_done),
        .wr_sym_i       (wr_sym),
        .wr_bank_free_o (wr_bank_free),
        .rd_ready_o     (rd_ready),
        .rd_sym_o       (rd_sym),
        .rd_release_i   (rd_release),
        .wb_cyc_i       (wb_cyc),
        .wb_stb_i       (wb_stb),
        .wb_adr_i       (wb_adr),
        .wb_dat_o       (wb_dat),
        .wb_ack_o       (wb_ack)
    );

    dft_engine #(
        .FFT_LOG2      (FFT_LOG2),
        .BAND_START    (BAND_START),
        .BAND_LEN      (BAND_LEN),
        .SYMS_PER_SYNC (SYMS_PER_SYNC)
    ) dft_engine_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .rd_ready_i   (rd_ready),
        .rd_sym_i     (rd_sym),
        .rd_release_o (rd_release),
        .wb_cyc_o     (wb_cyc),
        .wb_stb_o     (wb_stb),
        .wb_adr_o     (wb_adr),
        .wb_dat_i     (wb_dat),
        .wb_ack_i     (wb_ack),
        .out_valid_o  (out_valid_o),
        .out_data_o   (out_data_o),
        .out_last_o   (out_last_o),
        .out_sym_o    (out_sym_o),
        .out_sync_o   (out_sync_o)
    );

endmodule

// File: tb_ofdm_model.svh
// reference model of the demodulator, included into the testbench module body

localparam real MODEL_PI = 3.141592653589793;

// rounded twiddle w[i] = exp(-j*2*pi*i/N), real part
function automatic int twiddle_re(input int i);
    real ang;
    ang = 2.0 * MODEL_PI * i / FFT_LEN;
    return int'($floor(TWID_SCALE * $cos(ang) + 0.5));
endfunction

// imaginary part of the same twiddle
function automatic int twiddle_im(input int i);
    real ang;
    ang = 2.0 * MODEL_PI * i / FFT_LEN;
    return int'($floor(-TWID_SCALE * $sin(ang) + 0.5));
endfunction

// output index m of the band maps to a natural bin with DC moved to the middle
function automatic int natural_bin(input int m);
    return (BAND_START + m + FFT_LEN / 2) % FFT_LEN;
endfunction

// direct DFT of one bin, scaled by 2**-(15+log2 N) and cut to 16 bits per part
function automatic sample_t dft_bin(input sample_t x [FFT_LEN], input int k);
    longint acc_re;
    longint acc_im;
    longint xr;
    longint xi;
    longint wr;
    longint wi;
    longint re;
    longint im;
    int     n;
    acc_re = 0;
    acc_im = 0;
    for (n = 0; n < FFT_LEN; n++) begin
        xr = $signed(x[n][15:0]);
        xi = $signed(x[n][31:16]);
        wr = twiddle_re((k * n) % FFT_LEN);
        wi = twiddle_im((k * n) % FFT_LEN);
        acc_re += xr * wr - xi * wi;
        acc_im += xr * wi + xi * wr;
    end
    re = acc_re >>> (15 + FFT_LOG2);
    im = acc_im >>> (15 + FFT_LOG2);
    return {im[15:0], re[15:0]};
endfunction

// the first symbol of every synchronisation period
function automatic bit sync_symbol(input int sym);
    return (sym % SYMS_PER_SYNC) == 0;
endfunction

// File: tb_ofdm_demod.sv
`timescale 1ns/10ps

module tb_ofdm_demod;
    import ofdm_pkg::*;

    localparam int FFT_LOG2      = 4;
    localparam int FFT_LEN       = 1 << FFT_LOG2;
    localparam int BAND_START    = 2;
    localparam int BAND_LEN      = 12;
    localparam int SYMS_PER_SYNC = 14;
    localparam int WAIT_LIMIT    = 3000;    // two buffered symbols need about 820 cycles

    typedef struct packed {
        logic     sync;
        logic     last;
        sym_idx_t sym;
        sample_t  data;
    } exp_t;

    logic     clk_i;
    logic     reset_ni;
    logic     in_valid_i;
    sample_t  in_data_i;
    cp_len_t  in_cp_len_i;
    logic     in_last_i;
    logic     out_valid_o;
    sample_t  out_data_o;
    logic     out_last_o;
    sym_idx_t out_sym_o;
    logic     out_sync_o;
    logic     overflow_o;

    exp_t   exp_q [$];
    integer seed;
    int     sym_count;      // index the DUT should give the next symbol
    int     errors;
    int     errors_at_start;
    int     overflow_count;
    int     tests_run;
    int     tests_failed;
    string  cur_test;

    `include "tb_ofdm_model.svh"

    ofdm_demod_top dut_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_valid_i  (in_valid_i),
        .in_data_i   (in_data_i),
        .in_cp_len_i (in_cp_len_i),
        .in_last_i   (in_last_i),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o),
        .out_last_o  (out_last_o),
        .out_sym_o   (out_sym_o),
        .out_sync_o  (out_sync_o),
        .overflow_o  (overflow_o)
    );

    always #5 clk_i = ~clk_i;

    always @(negedge clk_i) begin
        if (reset_ni && overflow_o) overflow_count++;   // one pulse per dropped symbol
    end

    // every result is checked against the oldest expected entry
    always @(negedge clk_i) begin : compare
        exp_t e;
        if (reset_ni && out_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("%s: an output appeared while no result was expected", cur_test);
                errors++;
            end else begin
                e = exp_q.pop_front();
                assert (out_data_o == e.data) else begin
                    $display("error %s data: expected %h, actual %h", cur_test, e.data, out_data_o);
                    errors++;
                end
                assert (out_last_o == e.last) else begin
                    $display("error %s last: expected %b, actual %b", cur_test, e.last, out_last_o);
                    errors++;
                end
                assert (out_sym_o == e.sym) else begin
                    $display("error %s symbol: expected %0d, actual %0d", cur_test, e.sym, out_sym_o);
                    errors++;
                end
                assert (out_sync_o == e.sync) else begin
                    $display("error %s sync: expected %b, actual %b", cur_test, e.sync, out_sync_o);
                    errors++;
                end
            end
        end
    end

    function automatic void push_expected(input sample_t x [FFT_LEN], input int sym);
        exp_t e;
        int   m;
        for (m = 0; m < BAND_LEN; m++) begin
            e.data = dft_bin(x, natural_bin(m));
            e.last = (m == BAND_LEN - 1);
            e.sym  = sym_idx_t'(sym);
            e.sync = sync_symbol(sym);
            exp_q.push_back(e);
        end
    endfunction

    task automatic idle_input(input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(negedge clk_i);
            in_valid_i = 1'b0;
            in_last_i  = 1'b0;
        end
    endtask

    task automatic start_test(input string name);
        int i;
        cur_test   = name;
        reset_ni   = 1'b0;
        in_valid_i = 1'b0;
        in_last_i  = 1'b0;
        for (i = 0; i < 16; i++) @(negedge clk_i);
        reset_ni = 1'b1;
        exp_q.delete();
        sym_count       = 0;
        overflow_count  = 0;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("%s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", cur_test, errors - errors_at_start);
        end
    endtask

    task automatic report_and_finish();
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    // sends prefix, FFT_LEN kept samples and a tail, without a gap between samples
    task automatic drive_symbol(input int cp_len, input int tail, input bit expect_out);
        sample_t kept [FFT_LEN];
        sample_t smp;
        int      total;
        int      i;
        total = cp_len + FFT_LEN + tail;
        for (i = 0; i < total; i++) begin
            @(negedge clk_i);
            smp         = $random(seed);
            in_valid_i  = 1'b1;
            in_data_i   = smp;
            in_cp_len_i = cp_len_t'(cp_len);
            in_last_i   = (i == total - 1);
            if (i >= cp_len && i < cp_len + FFT_LEN) kept[i - cp_len] = smp;
        end
        if (expect_out) push_expected(kept, sym_count);
        sym_count++;                                // a dropped symbol still uses an index
    endtask

    task automatic wait_results();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: timed out with %0d results still missing", cur_test, exp_q.size());
            errors++;
            report_and_finish();
        end
    endtask

    initial begin : main
        int i;
        int s;
        clk_i       = 1'b0;
        reset_ni    = 1'b0;
        in_valid_i  = 1'b0;
        in_data_i   = '0;
        in_cp_len_i = '0;
        in_last_i   = 1'b0;
        seed         = 98;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;

        start_test("reset_idle");
        for (i = 0; i < 20; i++) begin
            @(negedge clk_i);
            assert (!out_valid_o && !overflow_o) else begin
                $display("%s: output valid or overflow went high without input", cur_test);
                errors++;
            end
        end
        finish_test();

        start_test("single_symbol");
        drive_symbol(4, 0, 1'b1);
        idle_input(1);
        wait_results();
        finish_test();

        start_test("prefix_and_tail");
        drive_symbol(0, 3, 1'b1);
        idle_input(1);
        wait_results();
        drive_symbol(7, 3, 1'b1);
        idle_input(1);
        wait_results();
        drive_symbol(20, 3, 1'b1);
        idle_input(1);
        wait_results();
        finish_test();

        start_test("symbol_index");
        for (s = 0; s < 16; s++) begin
            drive_symbol(s % 8, 0, 1'b1);
            idle_input(1);
            wait_results();
            idle_input(4);
        end
        finish_test();

        start_test("overflow_drop");
        drive_symbol(4, 0, 1'b1);
        drive_symbol(4, 0, 1'b1);
        drive_symbol(4, 0, 1'b0);
        idle_input(1);
        wait_results();
        idle_input(4);
        drive_symbol(4, 0, 1'b1);
        idle_input(1);
        wait_results();
        assert (overflow_count == 1) else begin
            $display("error %s overflow pulses: expected 1, actual %0d", cur_test, overflow_count);
            errors++;
        end
        finish_test();

        report_and_finish();
    end

endmodule

// File: ofdm_demod_top.f
+incdir+.
ofdm_pkg.sv
cp_remover.sv
symbol_buffer.sv
dft_engine.sv
ofdm_demod_top.sv
tb_ofdm_demod.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the fail message in the log
verilator --binary --assert -Wno-fatal --top-module tb_ofdm_demod \
    -f ofdm_demod_top.f --Mdir obj_dir -o sim > build.log 2>&1 &&
./obj_dir/sim > sim.log 2>&1 &&
cat sim.log &&
! grep -q "Some tests failed" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }
